// File: decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int REG_COUNT = 32;

    // Primary opcodes.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // R-type function codes.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_MFHI = 6'h10,
        FN_MFLO = 6'h12,
        FN_MULT = 6'h18,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI, ALU_PASS, ALU_MULT
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_HI, WB_LO} wb_sel_e;
    typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_RA} dest_sel_e;
    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;

    // Immediate is {rd, shamt, funct}, jump target is everything below opcode.
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_e    funct;
    } unpack_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      imm_zero_ext;
        dest_sel_e dest_sel;
        logic      write_reg;
        logic      mem_read;
        logic      mem_write;
        wb_sel_e   wb_sel;
        branch_e   branch;
        logic      jump;
        logic      jump_reg;
        logic      write_hi;
        logic      write_lo;
    } control_t;

    localparam word_t    NOP_INSTR = 32'h0000_0000;  // sll r0,r0,0.
    localparam control_t CTL_IDLE  = '0;

endpackage

// File: regfile_if.sv
`timescale 1ns/10ps

interface regfile_if;
    import decode_pkg::*;

    reg_addr_t ra0;
    reg_addr_t ra1;
    word_t     rd0;
    word_t     rd1;

    // Single write port from writeback.
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    modport stage (
        output ra0,
        output ra1,
        input  rd0,
        input  rd1,
        output we,
        output waddr,
        output wdata
    );

    modport regfile (
        input  ra0,
        input  ra1,
        output rd0,
        output rd1,
        input  we,
        input  waddr,
        input  wdata
    );

endinterface

// File: main_decoder.sv
`timescale 1ns/10ps

module main_decoder (
    input  decode_pkg::word_t    instruction,
    output decode_pkg::control_t ctl
);
    import decode_pkg::*;

    unpack_t unpack;

    assign unpack = unpack_t'(instruction);

    always_comb begin
        ctl = CTL_IDLE;
        case (unpack.opcode)
            OP_SPECIAL: begin
                case (unpack.funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
                        ctl.write_reg = 1'b1;
                        ctl.dest_sel  = DEST_RD;
                        case (unpack.funct)
                            FN_SUB:  ctl.alu_op = ALU_SUB;
                            FN_AND:  ctl.alu_op = ALU_AND;
                            FN_OR:   ctl.alu_op = ALU_OR;
                            FN_SLT:  ctl.alu_op = ALU_SLT;
                            default: ctl.alu_op = ALU_ADD;
                        endcase
                    end
                    FN_JR: ctl.jump_reg = 1'b1;
                    FN_MULT: begin
                        ctl.alu_op   = ALU_MULT;
                        ctl.write_hi = 1'b1;
                        ctl.write_lo = 1'b1;
                    end
                    FN_MFHI, FN_MFLO: begin
                        ctl.alu_op    = ALU_PASS;
                        ctl.write_reg = 1'b1;
                        ctl.dest_sel  = DEST_RD;
                        ctl.wb_sel    = (unpack.funct == FN_MFHI) ? WB_HI : WB_LO;
                    end
                    default: ctl = CTL_IDLE;  // Includes the shift nop.
                endcase
            end
            OP_J: ctl.jump = 1'b1;
            OP_JAL: begin
                ctl.jump      = 1'b1;
                ctl.alu_op    = ALU_PASS;  // Link value is pc plus four.
                ctl.write_reg = 1'b1;
                ctl.dest_sel  = DEST_RA;
            end
            OP_BEQ, OP_BNE: begin
                ctl.alu_op = ALU_SUB;
                ctl.branch = (unpack.opcode == OP_BEQ) ? BR_EQ : BR_NE;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_LUI: begin
                ctl.alu_src_imm = 1'b1;
                ctl.write_reg   = 1'b1;
                ctl.dest_sel    = DEST_RT;
                ctl.imm_zero_ext = (unpack.opcode == OP_ANDI) || (unpack.opcode == OP_ORI);
                case (unpack.opcode)
                    OP_SLTI: ctl.alu_op = ALU_SLT;
                    OP_ANDI: ctl.alu_op = ALU_AND;
                    OP_ORI:  ctl.alu_op = ALU_OR;
                    OP_LUI:  ctl.alu_op = ALU_LUI;
                    default: ctl.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                ctl.alu_src_imm = 1'b1;
                ctl.mem_read    = 1'b1;
                ctl.wb_sel      = WB_MEM;
                ctl.write_reg   = 1'b1;
                ctl.dest_sel    = DEST_RT;
            end
            OP_SW: begin
                ctl.alu_src_imm = 1'b1;
                ctl.mem_write   = 1'b1;
            end
            default: ctl = CTL_IDLE;
        endcase
    end

    // Table consistency across all opcodes.
    always_comb begin
        assert final (!(ctl.mem_read && ctl.mem_write))
            else $error("mem_read and mem_write both set");
        assert final (!(ctl.jump && ctl.branch != BR_NONE))
            else $error("jump and branch both set");
    end

endmodule

// File: register_file.sv
`timescale 1ns/10ps

module register_file (
    input logic pif,
    input logic arst_n,
    regfile_if.regfile rf
);
    import decode_pkg::*;

    word_t mem [1:REG_COUNT-1];  // No storage for r0.

    always_ff @(posedge pif or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (rf.we && rf.waddr != '0) begin
            mem[rf.waddr] <= rf.wdata;
        end
    end

    // Combinational reads, r0 hardwired.
    assign rf.rd0 = (rf.ra0 == '0) ? '0 : mem[rf.ra0];
    assign rf.rd1 = (rf.ra1 == '0) ? '0 : mem[rf.ra1];

    // Writeback address must be clean when it writes.
    assert property (@(posedge pif) disable iff (!arst_n)
        rf.we |-> !$isunknown(rf.waddr))
        else $error("register write with unknown address");

endmodule

// File: stage_decode.sv
`timescale 1ns/10ps

module stage_decode (
    input  logic                  pif,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  nullify,
    input  decode_pkg::word_t     in_instruction,
    input  decode_pkg::word_t     in_pc,
    input  logic                  wb_write_reg,
    input  decode_pkg::reg_addr_t wb_dest_reg,
    input  decode_pkg::word_t     wb_dest_data,
    input  logic                  wb_write_hi,
    input  decode_pkg::word_t     wb_hi_data,
    input  logic                  wb_write_lo,
    input  decode_pkg::word_t     wb_lo_data,
    input  logic                  fwd_rs_valid,
    input  decode_pkg::word_t     fwd_rs_data,
    input  logic                  fwd_rt_valid,
    input  decode_pkg::word_t     fwd_rt_data,
    input  logic                  fwd_hi_valid,
    input  decode_pkg::word_t     fwd_hi_data,
    input  logic                  fwd_lo_valid,
    input  decode_pkg::word_t     fwd_lo_data,
    regfile_if.stage              rf,
    output decode_pkg::word_t     out_instruction,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::word_t     out_pcadd4,
    output decode_pkg::word_t     out_pcjump,
    output decode_pkg::word_t     out_rs,
    output decode_pkg::word_t     out_rt,
    output decode_pkg::word_t     out_hi,
    output decode_pkg::word_t     out_lo,
    output decode_pkg::word_t     out_imm,
    output decode_pkg::control_t  out_ctl
);
    import decode_pkg::*;

    word_t    instr_q;
    word_t    pc_q;
    word_t    hi_q;
    word_t    lo_q;
    unpack_t  unpack;
    control_t ctl;
    logic [15:0] imm16;

    // Fetch latch. Nullify wins over stall.
    always_ff @(posedge pif or negedge arst_n) begin
        if (!arst_n) begin
            instr_q <= NOP_INSTR;
            pc_q    <= '0;
        end else if (nullify) begin
            instr_q <= NOP_INSTR;
            pc_q    <= '0;
        end else if (!stall) begin
            instr_q <= in_instruction;
            pc_q    <= in_pc;
        end
    end

    always_ff @(posedge pif or negedge arst_n) begin
        if (!arst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (wb_write_hi) hi_q <= wb_hi_data;
            if (wb_write_lo) lo_q <= wb_lo_data;
        end
    end

    main_decoder u_decoder (
        .instruction (instr_q),
        .ctl         (ctl)
    );

    assign unpack = unpack_t'(instr_q);
    assign imm16  = {unpack.rd, unpack.shamt, unpack.funct};

    assign rf.ra0   = unpack.rs;
    assign rf.ra1   = unpack.rt;
    assign rf.we    = wb_write_reg;  // Writeback keeps going under stall.
    assign rf.waddr = wb_dest_reg;
    assign rf.wdata = wb_dest_data;

    assign out_instruction = instr_q;
    assign out_pc          = pc_q;
    assign out_pcadd4      = pc_q + 32'd4;
    assign out_pcjump      = {out_pcadd4[31:28], instr_q[25:0], 2'b00};
    assign out_imm = ctl.imm_zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    assign out_ctl = ctl;

    // Bypass from later stages.
    assign out_rs = fwd_rs_valid ? fwd_rs_data : rf.rd0;
    assign out_rt = fwd_rt_valid ? fwd_rt_data : rf.rd1;
    assign out_hi = fwd_hi_valid ? fwd_hi_data : hi_q;
    assign out_lo = fwd_lo_valid ? fwd_lo_data : lo_q;

    // Fetch must never hand over an unknown instruction.
    assert property (@(posedge pif) disable iff (!arst_n) !$isunknown(instr_q))
        else $error("latched instruction is unknown");

endmodule

// File: decode_top.sv
`timescale 1ns/10ps

module decode_top (
    input  logic                  pif,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  nullify,
    input  decode_pkg::word_t     in_instruction,
    input  decode_pkg::word_t     in_pc,
    input  logic                  wb_write_reg,
    input  decode_pkg::reg_addr_t wb_dest_reg,
    input  decode_pkg::word_t     wb_dest_data,
    input  logic                  wb_write_hi,
    input  decode_pkg::word_t     wb_hi_data,
    input  logic                  wb_write_lo,
    input  decode_pkg::word_t     wb_lo_data,
    input  logic                  fwd_rs_valid,
    input  decode_pkg::word_t     fwd_rs_data,
    input  logic                  fwd_rt_valid,
    input  decode_pkg::word_t     fwd_rt_data,
    input  logic                  fwd_hi_valid,
    input  decode_pkg::word_t     fwd_hi_data,
    input  logic                  fwd_lo_valid,
    input  decode_pkg::word_t     fwd_lo_data,
    output decode_pkg::word_t     out_instruction,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::word_t     out_pcadd4,
    output decode_pkg::word_t     out_pcjump,
    output decode_pkg::word_t     out_rs,
    output decode_pkg::word_t     out_rt,
    output decode_pkg::word_t     out_hi,
    output decode_pkg::word_t     out_lo,
    output decode_pkg::word_t     out_imm,
    output decode_pkg::control_t  ctl
);

    regfile_if rf_bus ();

    stage_decode u_stage (
        .pif             (pif),
        .arst_n          (arst_n),
        .stall           (stall),
        .nullify         (nullify),
        .in_instruction  (in_instruction),
        .in_pc           (in_pc),
        .wb_write_reg    (wb_write_reg),
        .wb_dest_reg     (wb_dest_reg),
        .wb_dest_data    (wb_dest_data),
        .wb_write_hi     (wb_write_hi),
        .wb_hi_data      (wb_hi_data),
        .wb_write_lo     (wb_write_lo),
        .wb_lo_data      (wb_lo_data),
        .fwd_rs_valid    (fwd_rs_valid),
        .fwd_rs_data     (fwd_rs_data),
        .fwd_rt_valid    (fwd_rt_valid),
        .fwd_rt_data     (fwd_rt_data),
        .fwd_hi_valid    (fwd_hi_valid),
        .fwd_hi_data     (fwd_hi_data),
        .fwd_lo_valid    (fwd_lo_valid),
        .fwd_lo_data     (fwd_lo_data),
        .rf              (rf_bus.stage),
        .out_instruction (out_instruction),
        .out_pc          (out_pc),
        .out_pcadd4      (out_pcadd4),
        .out_pcjump      (out_pcjump),
        .out_rs          (out_rs),
        .out_rt          (out_rt),
        .out_hi          (out_hi),
        .out_lo          (out_lo),
        .out_imm         (out_imm),
        .out_ctl         (ctl)
    );

    register_file u_regfile (
        .pif    (pif),
        .arst_n (arst_n),
        .rf     (rf_bus.regfile)
    );

endmodule

// File: tb_decode_top.sv
`timescale 1ns/10ps

module tb_decode_top;
    import decode_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int SAMPLE_DELAY = 8;  // Late in the high phase.

    // Fields: alu_op, {src_imm, zero_ext}, dest, {write_reg, mem_read, mem_write},
    // wb_sel, branch, {jump, jump_reg, write_hi, write_lo}.
    localparam control_t C_NOP  = '0;
    localparam control_t C_ADD  = {ALU_ADD,  2'b00, DEST_RD, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_SUB  = {ALU_SUB,  2'b00, DEST_RD, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_AND  = {ALU_AND,  2'b00, DEST_RD, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_OR   = {ALU_OR,   2'b00, DEST_RD, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_SLT  = {ALU_SLT,  2'b00, DEST_RD, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_JR   = {ALU_ADD,  2'b00, DEST_RD, 3'b000, WB_ALU, BR_NONE, 4'b0100};
    localparam control_t C_MULT = {ALU_MULT, 2'b00, DEST_RD, 3'b000, WB_ALU, BR_NONE, 4'b0011};
    localparam control_t C_MFHI = {ALU_PASS, 2'b00, DEST_RD, 3'b100, WB_HI,  BR_NONE, 4'b0000};
    localparam control_t C_MFLO = {ALU_PASS, 2'b00, DEST_RD, 3'b100, WB_LO,  BR_NONE, 4'b0000};
    localparam control_t C_J    = {ALU_ADD,  2'b00, DEST_RD, 3'b000, WB_ALU, BR_NONE, 4'b1000};
    localparam control_t C_JAL  = {ALU_PASS, 2'b00, DEST_RA, 3'b100, WB_ALU, BR_NONE, 4'b1000};
    localparam control_t C_BEQ  = {ALU_SUB,  2'b00, DEST_RD, 3'b000, WB_ALU, BR_EQ,   4'b0000};
    localparam control_t C_BNE  = {ALU_SUB,  2'b00, DEST_RD, 3'b000, WB_ALU, BR_NE,   4'b0000};
    localparam control_t C_ADDI = {ALU_ADD,  2'b10, DEST_RT, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_SLTI = {ALU_SLT,  2'b10, DEST_RT, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_ANDI = {ALU_AND,  2'b11, DEST_RT, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_ORI  = {ALU_OR,   2'b11, DEST_RT, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_LUI  = {ALU_LUI,  2'b10, DEST_RT, 3'b100, WB_ALU, BR_NONE, 4'b0000};
    localparam control_t C_LW   = {ALU_ADD,  2'b10, DEST_RT, 3'b110, WB_MEM, BR_NONE, 4'b0000};
    localparam control_t C_SW   = {ALU_ADD,  2'b10, DEST_RD, 3'b001, WB_ALU, BR_NONE, 4'b0000};

    typedef struct packed {
        word_t      instr;
        word_t      pc;
        logic [1:0] stall_nullify;
        logic [2:0] wb_flags;   // write_reg, write_hi, write_lo.
        reg_addr_t  wb_dest;
        logic [3:0] fwd_valid;  // rs, rt, hi, lo.
        word_t      exp_pc;
        word_t      exp_pcjump;
        word_t      exp_imm;
        control_t   exp_ctl;
    } row_t;

    logic      pif;
    logic      arst_n;
    logic      stall;
    logic      nullify;
    word_t     in_instruction;
    word_t     in_pc;
    logic      wb_write_reg;
    reg_addr_t wb_dest_reg;
    word_t     wb_dest_data;
    logic      wb_write_hi;
    word_t     wb_hi_data;
    logic      wb_write_lo;
    word_t     wb_lo_data;
    logic      fwd_rs_valid;
    word_t     fwd_rs_data;
    logic      fwd_rt_valid;
    word_t     fwd_rt_data;
    logic      fwd_hi_valid;
    word_t     fwd_hi_data;
    logic      fwd_lo_valid;
    word_t     fwd_lo_data;
    word_t     out_instruction;
    word_t     out_pc;
    word_t     out_pcadd4;
    word_t     out_pcjump;
    word_t     out_rs;
    word_t     out_rt;
    word_t     out_hi;
    word_t     out_lo;
    word_t     out_imm;
    control_t  ctl;

    row_t        rows[$];
    logic        rows_ready = 1'b0;
    logic [31:0] lfsr_state;
    int          fail_count;
    word_t       model_reg [REG_COUNT];
    word_t       model_hi;
    word_t       model_lo;
    word_t       latch_instr;

    decode_top dut_i (.*);

    always #(HALF_PERIOD) pif = ~pif;

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output word_t w);
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_count++;
            $display("FAILED at time %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_ctl(input string name, input control_t got, input control_t exp);
        if (got !== exp) begin
            fail_count++;
            $display("FAILED at time %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic add_row(input word_t instr, input word_t pc, input logic [1:0] sn,
                           input logic [2:0] wb, input reg_addr_t dest, input logic [3:0] fwd,
                           input word_t exp_pc, input word_t exp_pcjump, input word_t exp_imm,
                           input control_t exp_ctl);
        row_t r;
        r = {instr, pc, sn, wb, dest, fwd, exp_pc, exp_pcjump, exp_imm, exp_ctl};
        rows.push_back(r);
    endtask

    task automatic build_table();
        word_t instr;
        word_t pc;
        // Stalled right after reset, so the reset NOP is still latched.
        add_row('h0022_1820, 'h0100, 2'b10, 3'b000, 0, 4'h0, 'h0, 'h0, 'h0, C_NOP);
        // Sweep r1..r31, reading rs = i and rt = i - 1.
        for (int i = 1; i < REG_COUNT; i++) begin
            instr = (i << 21) | ((i - 1) << 16) | 32'h20;
            pc = 32'h1000 + 4 * i;
            add_row(instr, pc, 2'b00, 3'b100, i, 4'h0, pc, {4'h0, instr[25:0], 2'b00},
                    'h20, C_ADD);
        end
        add_row('h0000_0020, 'h1100, 2'b00, 3'b100, 0, 4'h0, 'h1100, 'h0000_0080, 'h20, C_ADD);
        add_row('h0022_1820, 'h2000, 2'b00, 3'b000, 0, 4'h0, 'h2000, 'h0088_6080, 'h1820, C_ADD);
        add_row('h0022_1821, 'h2004, 2'b00, 3'b000, 0, 4'h0, 'h2004, 'h0088_6084, 'h1821, C_ADD);
        add_row('h0022_1822, 'h2008, 2'b00, 3'b000, 0, 4'h0, 'h2008, 'h0088_6088, 'h1822, C_SUB);
        add_row('h0022_1824, 'h200c, 2'b00, 3'b000, 0, 4'h0, 'h200c, 'h0088_6090, 'h1824, C_AND);
        add_row('h0022_1825, 'h2010, 2'b00, 3'b000, 0, 4'hf, 'h2010, 'h0088_6094, 'h1825, C_OR);
        add_row('h0022_182a, 'h2014, 2'b00, 3'b100, 3, 4'h0, 'h2014, 'h0088_60a8, 'h182a, C_SLT);
        add_row('h0022_1808, 'h2018, 2'b00, 3'b000, 0, 4'h0, 'h2018, 'h0088_6020, 'h1808, C_JR);
        add_row('h0022_1818, 'h201c, 2'b00, 3'b011, 0, 4'h0, 'h201c, 'h0088_6060, 'h1818, C_MULT);
        add_row('h0022_1810, 'h2020, 2'b00, 3'b010, 0, 4'h0, 'h2020, 'h0088_6040, 'h1810, C_MFHI);
        add_row('h0022_1812, 'h2024, 2'b00, 3'b001, 0, 4'h0, 'h2024, 'h0088_6048, 'h1812, C_MFLO);
        add_row('h0022_183f, 'h2028, 2'b00, 3'b000, 0, 4'ha, 'h2028, 'h0088_60fc, 'h183f, C_NOP);
        add_row('h2022_8001, 'h202c, 2'b00, 3'b000, 0, 4'h0, 'h202c, 'h008a_0004, 'hffff_8001,
                C_ADDI);
        add_row('h2422_0010, 'h2030, 2'b00, 3'b000, 0, 4'h0, 'h2030, 'h0088_0040, 'h10, C_ADDI);
        add_row('h2822_fff0, 'h2034, 2'b00, 3'b000, 0, 4'h0, 'h2034, 'h008b_ffc0, 'hffff_fff0,
                C_SLTI);
        add_row('h3022_8421, 'h2038, 2'b00, 3'b000, 0, 4'h0, 'h2038, 'h008a_1084, 'h8421, C_ANDI);
        add_row('h3422_f00f, 'h203c, 2'b00, 3'b000, 0, 4'h0, 'h203c, 'h008b_c03c, 'hf00f, C_ORI);
        add_row('h3c22_1234, 'h2040, 2'b00, 3'b000, 0, 4'h0, 'h2040, 'h0088_48d0, 'h1234, C_LUI);
        add_row('h8c22_fffc, 'h2044, 2'b00, 3'b000, 0, 4'h0, 'h2044, 'h008b_fff0, 'hffff_fffc,
                C_LW);
        add_row('hac22_0008, 'h2048, 2'b00, 3'b000, 0, 4'h0, 'h2048, 'h0088_0020, 'h8, C_SW);
        add_row('h1022_0003, 'h204c, 2'b00, 3'b000, 0, 4'h0, 'h204c, 'h0088_000c, 'h3, C_BEQ);
        add_row('h1422_fffe, 'h2050, 2'b00, 3'b000, 0, 4'h0, 'h2050, 'h008b_fff8, 'hffff_fffe,
                C_BNE);
        add_row('hfc22_0000, 'h2054, 2'b00, 3'b000, 0, 4'h0, 'h2054, 'h0088_0000, 'h0, C_NOP);
        add_row('h0812_3456, 'h2058, 2'b00, 3'b000, 0, 4'h0, 'h2058, 'h0048_d158, 'h3456, C_J);
        add_row('h0eab_cdef, 'h8000_0ffc, 2'b00, 3'b000, 0, 4'h0, 'h8000_0ffc, 'h8aaf_37bc,
                'hffff_cdef, C_JAL);
        // Hold addiu while r1 is rewritten, then nullify under stall.
        add_row('h2422_0010, 'h3000, 2'b00, 3'b000, 0, 4'h0, 'h3000, 'h0088_0040, 'h10, C_ADDI);
        add_row('h0022_1820, 'h3004, 2'b10, 3'b100, 1, 4'h0, 'h3000, 'h0088_0040, 'h10, C_ADDI);
        add_row('h0022_1820, 'h3008, 2'b11, 3'b100, 2, 4'h0, 'h0, 'h0, 'h0, C_NOP);
        add_row('h0022_1820, 'h300c, 2'b00, 3'b000, 0, 4'h0, 'h300c, 'h0088_6080, 'h1820, C_ADD);
    endtask

    task automatic apply_row(input row_t r);
        word_t wb_data;
        word_t hi_data;
        word_t lo_data;
        word_t fwd_base;
        word_t exp_rs;
        word_t exp_rt;
        word_t exp_hi;
        word_t exp_lo;
        draw_word(wb_data);
        draw_word(hi_data);
        draw_word(lo_data);
        draw_word(fwd_base);
        @(negedge pif);
        {stall, nullify} = r.stall_nullify;
        in_instruction = r.instr;
        in_pc = r.pc;
        {wb_write_reg, wb_write_hi, wb_write_lo} = r.wb_flags;
        wb_dest_reg  = r.wb_dest;
        wb_dest_data = wb_data;
        wb_hi_data   = hi_data;
        wb_lo_data   = lo_data;
        {fwd_rs_valid, fwd_rt_valid, fwd_hi_valid, fwd_lo_valid} = r.fwd_valid;
        fwd_rs_data = fwd_base;
        fwd_rt_data = ~fwd_base;
        fwd_hi_data = {fwd_base[15:0], fwd_base[31:16]};
        fwd_lo_data = fwd_base ^ 32'hffff_0000;
        @(posedge pif);
        if (r.wb_flags[2] && r.wb_dest != 0) model_reg[r.wb_dest] = wb_data;  // r0 stays zero.
        if (r.wb_flags[1]) model_hi = hi_data;
        if (r.wb_flags[0]) model_lo = lo_data;
        if (r.stall_nullify[0]) begin
            latch_instr = NOP_INSTR;
        end else if (!r.stall_nullify[1]) begin
            latch_instr = r.instr;
        end
        #(SAMPLE_DELAY);
        exp_rs = r.fwd_valid[3] ? fwd_rs_data : model_reg[latch_instr[25:21]];
        exp_rt = r.fwd_valid[2] ? fwd_rt_data : model_reg[latch_instr[20:16]];
        exp_hi = r.fwd_valid[1] ? fwd_hi_data : model_hi;
        exp_lo = r.fwd_valid[0] ? fwd_lo_data : model_lo;
        check_word("out_instruction", out_instruction, latch_instr);
        check_word("out_pc", out_pc, r.exp_pc);
        check_word("out_pcadd4", out_pcadd4, r.exp_pc + 32'd4);
        check_word("out_pcjump", out_pcjump, r.exp_pcjump);
        check_word("out_rs", out_rs, exp_rs);
        check_word("out_rt", out_rt, exp_rt);
        check_word("out_hi", out_hi, exp_hi);
        check_word("out_lo", out_lo, exp_lo);
        check_word("out_imm", out_imm, r.exp_imm);
        check_ctl("ctl", ctl, r.exp_ctl);
    endtask

    initial begin
        pif = 1'b0;
        arst_n = 1'b0;
        stall = 1'b1;  // Keeps the reset NOP latched until the first row.
        nullify = 1'b0;
        in_instruction = '0;
        in_pc = '0;
        wb_write_reg = 1'b0;
        wb_dest_reg = '0;
        wb_dest_data = '0;
        wb_write_hi = 1'b0;
        wb_hi_data = '0;
        wb_write_lo = 1'b0;
        wb_lo_data = '0;
        {fwd_rs_valid, fwd_rt_valid, fwd_hi_valid, fwd_lo_valid} = 4'h0;
        fwd_rs_data = '0;
        fwd_rt_data = '0;
        fwd_hi_data = '0;
        fwd_lo_data = '0;
        lfsr_state = 32'h90420b3e;
        fail_count = 0;
        foreach (model_reg[i]) model_reg[i] = '0;
        model_hi = '0;
        model_lo = '0;
        latch_instr = NOP_INSTR;
        build_table();
        rows_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge pif);
        @(negedge pif);
        arst_n = 1'b1;
        foreach (rows[k]) apply_row(rows[k]);
        if (fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

    // Two clock periods per row plus reset, with some slack.
    initial begin
        int unsigned limit_ns;
        wait (rows_ready);
        limit_ns = (rows.size() + RESET_CYCLES) * 40 + 400;
        #(limit_ns);
        $display("Timeout: the stimulus table did not finish within %0d ns", limit_ns);
        stop_with_failure();
    end

endmodule

// File: decode_top.f
decode_pkg.sv
regfile_if.sv
main_decoder.sv
register_file.sv
stage_decode.sv
decode_top.sv
tb_decode_top.sv

// File: Bender.yml
package:
  name: decode_top

sources:
  - decode_pkg.sv
  - regfile_if.sv
  - main_decoder.sv
  - register_file.sv
  - stage_decode.sv
  - decode_top.sv
  - target: test
    files:
      - tb_decode_top.sv
